// File: common/core_cfg_pkg.sv
/* Core-wide widths, register index type and reset vector. */
package core_cfg_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;  // data and address
    typedef logic [4:0]      reg_idx_t;

    localparam word_t RESET_PC   = 32'h8000_0000;
    localparam word_t INST_BYTES = 32'd4;  // sequential pc step

endpackage

// File: common/rv_isa_pkg.sv
/* RV32I encodings and decode enums shared by the decode and execute stages.
   Import into any module that classifies or executes instructions. */
package rv_isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // major opcodes kept by this core
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000;  // sub / sra

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,  // also jalr
        FMT_U,
        FMT_J,
        FMT_B,
        FMT_N   // unknown opcode, retires as a nop
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

endpackage

// File: fetch/fetch_stage.sv
/* Holds pc and the current instruction, and steps each instruction through
   request, wait-for-memory and a single execute cycle. */
`timescale 1ns/1ns

module fetch_stage import core_cfg_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  imem_valid,
    input  word_t imem_data,
    input  word_t next_pc,
    output logic  imem_req,
    output word_t imem_addr,
    output word_t inst,
    output word_t pc,
    output logic  exec_valid
);

    typedef enum logic [1:0] {
        REQ,
        WAIT,
        EXEC
    } fetch_state_t;

    fetch_state_t state;

    // imem_req is registered so it stays low through reset;
    // right after reset REQ spends one extra cycle raising it
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= REQ;
            imem_req <= 1'b0;
        end else begin
            case (state)
                REQ: begin
                    if (imem_req) begin
                        imem_req <= 1'b0;
                        state    <= WAIT;
                    end else begin
                        imem_req <= 1'b1;
                    end
                end
                WAIT: if (imem_valid) state <= EXEC;
                EXEC: begin
                    imem_req <= 1'b1;  // next fetch right after retire
                    state    <= REQ;
                end
                default: state <= REQ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (state == EXEC) begin
            pc <= next_pc;  // same edge as the register write
        end
    end

    // stray strobes outside WAIT are dropped
    always_ff @(posedge clk) begin
        if (state == WAIT && imem_valid) inst <= imem_data;
    end

    assign exec_valid = (state == EXEC);
    assign imem_addr  = pc;

    a_req_only_in_req: assert property (@(posedge clk) disable iff (reset)
        imem_req |-> state == REQ);

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

// File: rtl/core_top.sv
/* Multicycle RV32I core top: fetch, decode, register file and execute,
   with an instruction memory port and a retire port for checking. */
`timescale 1ns/1ns

module core_top import rv_isa_pkg::*, core_cfg_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    output logic     imem_req,
    output word_t    imem_addr,
    input  logic     imem_valid,
    input  word_t    imem_data,
    output logic     retire_valid,
    output word_t    retire_pc,
    output logic     retire_we,
    output reg_idx_t retire_rd,
    output word_t    retire_data
);

    word_t     inst;
    word_t     pc;
    word_t     next_pc;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     rd_wdata;
    logic      exec_valid;
    logic      rd_we;
    opcode_t   opcode;
    funct3_t   funct3;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    inst_fmt_t fmt;
    alu_op_t   alu_op;

    fetch_stage fetch_i (
        .clk        (clk),
        .reset      (reset),
        .imem_valid (imem_valid),
        .imem_data  (imem_data),
        .next_pc    (next_pc),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .inst       (inst),
        .pc         (pc),
        .exec_valid (exec_valid)
    );

    decode_stage decode_i (
        .inst   (inst),
        .opcode (opcode),
        .funct3 (funct3),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .imm    (imm),
        .fmt    (fmt),
        .alu_op (alu_op)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .reset  (reset),
        .we     (rd_we),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (rd_wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    execute_stage execute_i (
        .exec_valid (exec_valid),
        .fmt        (fmt),
        .alu_op     (alu_op),
        .opcode     (opcode),
        .funct3     (funct3),
        .pc         (pc),
        .imm        (imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .next_pc    (next_pc),
        .rd_we      (rd_we),
        .rd_wdata   (rd_wdata)
    );

    // retire reports the execute cycle as it happens
    assign retire_valid = exec_valid;
    assign retire_pc    = pc;
    assign retire_we    = rd_we;
    assign retire_rd    = rd;
    assign retire_data  = rd_wdata;

endmodule

// File: rtl/decode_stage.sv
/* Combinational decode: register fields, instruction format, sign-extended
   immediate and the ALU operation for the execute stage. */
`timescale 1ns/1ns

module decode_stage import rv_isa_pkg::*, core_cfg_pkg::*; (
    input  word_t     inst,
    output opcode_t   opcode,
    output funct3_t   funct3,
    output reg_idx_t  rs1,
    output reg_idx_t  rs2,
    output reg_idx_t  rd,
    output word_t     imm,
    output inst_fmt_t fmt,
    output alu_op_t   alu_op
);

    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            OPC_OP:               fmt = FMT_R;
            OPC_OP_IMM, OPC_JALR: fmt = FMT_I;
            OPC_LUI, OPC_AUIPC:   fmt = FMT_U;
            OPC_JAL:              fmt = FMT_J;
            OPC_BRANCH:           fmt = FMT_B;
            default:              fmt = FMT_N;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I: imm = {{20{inst[31]}}, inst[31:20]};
            FMT_U: imm = {inst[31:12], 12'b0};
            FMT_J: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            FMT_B: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            default: imm = '0;
        endcase
    end

    // address math for jumps, branches and auipc all uses add
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                3'b000: begin
                    // addi has no sub form
                    if (fmt == FMT_R && funct7 == F7_ALT) alu_op = ALU_SUB;
                end
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;  // srai too
                3'b110: alu_op = ALU_OR;
                3'b111: alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

endmodule

// File: rtl/execute_stage.sv
/* Combinational execute: operand mux, ALU, branch compare, next pc and the
   writeback value and enable for the register file. */
`timescale 1ns/1ns

module execute_stage import rv_isa_pkg::*, core_cfg_pkg::*; (
    input  logic      exec_valid,
    input  inst_fmt_t fmt,
    input  alu_op_t   alu_op,
    input  opcode_t   opcode,
    input  funct3_t   funct3,
    input  word_t     pc,
    input  word_t     imm,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output word_t     next_pc,
    output logic      rd_we,
    output word_t     rd_wdata
);

    word_t      op_a;
    word_t      op_b;
    word_t      alu_res;
    word_t      seq_pc;
    word_t      target;
    logic [4:0] shamt;
    logic       taken;
    logic       is_jump;

    always_comb begin
        op_a = rs1_data;
        op_b = imm;
        case (fmt)
            FMT_R:        op_b = rs2_data;
            FMT_U:        op_a = (opcode == OPC_LUI) ? '0 : pc;
            FMT_J, FMT_B: op_a = pc;
            default:      op_a = rs1_data;  // I format
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = word_t'($signed(op_a) >>> shamt);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    // compare the raw register values, the alu is busy with the target
    always_comb begin
        case (funct3)
            F3_BEQ:  taken = (rs1_data == rs2_data);
            F3_BNE:  taken = (rs1_data != rs2_data);
            F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            F3_BLTU: taken = (rs1_data < rs2_data);
            F3_BGEU: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign is_jump = (fmt == FMT_J) || (opcode == OPC_JALR);
    assign seq_pc  = pc + INST_BYTES;
    assign target  = (opcode == OPC_JALR) ? {alu_res[XLEN-1:1], 1'b0} : alu_res;

    assign next_pc = (is_jump || (fmt == FMT_B && taken)) ? target : seq_pc;

    assign rd_we = exec_valid &&
        (fmt == FMT_R || fmt == FMT_I || fmt == FMT_U || fmt == FMT_J);
    assign rd_wdata = is_jump ? seq_pc : alu_res;  // link address for jal/jalr

    // a jump landing off a word boundary would fetch garbage next
    always_comb begin
        if (rd_we && is_jump) begin
            a_jump_aligned: assert final (next_pc[1:0] == 2'b00);
        end
    end

endmodule

// File: rtl/reg_file.sv
/* 32-entry integer register file with two combinational read ports and one
   synchronous write port; x0 reads as zero. */
`timescale 1ns/1ns

module reg_file import core_cfg_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t waddr,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // the fetch FSM must hold off execute while the core is in reset
    a_no_write_in_reset: assert property (@(posedge clk) reset |-> !we);

endmodule

// File: run_verilator.sh
#!/bin/sh
# build the core testbench with Verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module core_tb -o core_tb_sim &&
./obj_dir/core_tb_sim | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }

// File: tb/core_tb.sv
/* Testbench for the multicycle core: a random-latency instruction memory serves
   a random instruction stream, and a reference model checks every retire. */
`timescale 1ns/1ns

module core_tb import rv_isa_pkg::*, core_cfg_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTS = 300;
    localparam int MAX_INSTS = 400;
    localparam int TIMEOUT_NS = MAX_INSTS * 8 * CLK_PERIOD;  // 8 cycles per instruction

    logic     clk;
    logic     reset;
    logic     imem_req;
    word_t    imem_addr;
    logic     imem_valid;
    word_t    imem_data;
    logic     retire_valid;
    word_t    retire_pc;
    logic     retire_we;
    reg_idx_t retire_rd;
    word_t    retire_data;

    logic [15:0] lfsr_state;
    word_t       model_regs [NUM_REGS];
    word_t       exp_pc;
    word_t       fetched_inst;  // word handed out for the current request
    logic        outstanding;
    int          retire_count;

    core_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_valid   (imem_valid),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    task automatic fail_value(input string name, input word_t expected, input word_t actual);
        $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic fail_plain(input string what);
        $display("protocol error: %s", what);
        $display("TEST FAILED");
        $fatal(1, "stopped at first protocol error");
    endtask

    // 16-bit fibonacci with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output word_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};  // one step per bit
        end
    endtask

    // registers limited to x0..x7 so results get reused and x0 shows up often
    task automatic gen_inst(output word_t inst);
        word_t      kind;
        word_t      rd;
        word_t      rs1;
        word_t      rs2;
        word_t      f3;
        word_t      r;
        word_t      off;
        logic [6:0] f7;
        logic [2:0] bf3;
        logic [6:0] unk;
        take_bits(4, kind);
        take_bits(3, rd);
        take_bits(3, rs1);
        take_bits(3, rs2);
        take_bits(3, f3);
        take_bits(20, r);
        f7 = (r[0] && (f3 == 32'd0 || f3 == 32'd5)) ? F7_ALT : 7'b0;
        off = {{20{r[9]}}, r[9:0], 2'b00};  // word aligned jump / branch offset
        bf3 = (f3[2:1] == 2'b01) ? (f3[2:0] ^ 3'b110) : f3[2:0];
        case (r[1:0])
            2'd0: unk = 7'b0000011;  // load
            2'd1: unk = 7'b0100011;  // store
            2'd2: unk = 7'b1110011;  // system
            default: unk = 7'b0001111;
        endcase
        case (kind)
            0, 1, 2, 3: inst = {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
            4, 5, 6: begin
                if (f3 == 32'd1 || f3 == 32'd5) begin
                    inst = {f7, r[5:1], rs1[4:0], f3[2:0], rd[4:0], OPC_OP_IMM};
                end else begin
                    inst = {r[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP_IMM};
                end
            end
            7: inst = {r[19:0], rd[4:0], OPC_LUI};
            8: inst = {r[19:0], rd[4:0], OPC_AUIPC};
            9: inst = {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
            10: inst = {r[9:0], 2'b00, 5'd0, 3'b000, rd[4:0], OPC_JALR};
            11, 12, 13: begin
                inst = {off[12], off[10:5], rs2[4:0], rs1[4:0], bf3, off[4:1], off[11],
                        OPC_BRANCH};
            end
            14: inst = {r[19:0], rd[4:0], unk};
            default: inst = {r[11:0], rs1[4:0], 3'b000, 5'd0, OPC_OP_IMM};  // addi x0
        endcase
    endtask

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input logic is_reg, input word_t a, input word_t b);
        case (f3)
            3'b000: alu_ref = (is_reg && alt) ? a - b : a + b;
            3'b001: alu_ref = a << b[4:0];
            3'b010: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: alu_ref = (a < b) ? 32'd1 : 32'd0;
            3'b100: alu_ref = a ^ b;
            3'b101: alu_ref = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    task automatic check_retire();
        word_t    inst;
        opcode_t  opc;
        funct3_t  f3;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    imm_i;
        word_t    imm_u;
        word_t    imm_j;
        word_t    imm_b;
        word_t    seq;
        word_t    exp_data;
        word_t    exp_next;
        logic     exp_we;
        logic     taken;
        inst = fetched_inst;
        opc = inst[6:0];
        rd = inst[11:7];
        f3 = inst[14:12];
        a = model_regs[inst[19:15]];
        b = model_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_u = {inst[31:12], 12'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        seq = exp_pc + 32'd4;
        exp_we = 1'b1;
        exp_data = '0;
        exp_next = seq;
        taken = 1'b0;
        case (opc)
            OPC_OP:     exp_data = alu_ref(f3, inst[30], 1'b1, a, b);
            OPC_OP_IMM: exp_data = alu_ref(f3, inst[30], 1'b0, a, imm_i);
            OPC_LUI:    exp_data = imm_u;
            OPC_AUIPC:  exp_data = exp_pc + imm_u;
            OPC_JAL: begin
                exp_data = seq;
                exp_next = exp_pc + imm_j;
            end
            OPC_JALR: begin
                exp_data = seq;
                exp_next = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                exp_we = 1'b0;
                case (f3)
                    F3_BEQ:  taken = (a == b);
                    F3_BNE:  taken = (a != b);
                    F3_BLT:  taken = ($signed(a) < $signed(b));
                    F3_BGE:  taken = ($signed(a) >= $signed(b));
                    F3_BLTU: taken = (a < b);
                    F3_BGEU: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) exp_next = exp_pc + imm_b;
            end
            default: exp_we = 1'b0;  // unknown opcode acts as a nop
        endcase
        assert (retire_pc == exp_pc) else fail_value("retire pc", exp_pc, retire_pc);
        assert (retire_we == exp_we)
            else fail_value("retire write enable", word_t'(exp_we), word_t'(retire_we));
        if (exp_we) begin
            assert (retire_rd == rd)
                else fail_value("retire rd", word_t'(rd), word_t'(retire_rd));
            assert (retire_data == exp_data)
                else fail_value("retire data", exp_data, retire_data);
            if (rd != '0) model_regs[rd] = exp_data;  // x0 stays zero
        end
        exp_pc = exp_next;
        retire_count++;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        lfsr_state = 16'd85;
        exp_pc = RESET_PC;
        retire_count = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        wait (retire_count == NUM_INSTS);
        $display("%0d instructions retired", retire_count);
        $display("TEST PASSED");
        $finish;
    end

    // memory answers 1 to 4 cycles after the request cycle
    initial begin : memory_model
        word_t delay;
        imem_valid = 1'b0;
        imem_data = '0;
        fetched_inst = '0;
        forever begin
            @(negedge clk);
            if (!reset && imem_req) begin
                take_bits(2, delay);
                gen_inst(fetched_inst);
                repeat (delay + 1) @(posedge clk);
                #1;
                imem_valid = 1'b1;
                imem_data = fetched_inst;
                @(posedge clk);
                #1;
                imem_valid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (imem_req) begin
            outstanding <= 1'b1;
        end else if (imem_valid) begin
            outstanding <= 1'b0;
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (imem_req) begin
                assert (imem_addr == exp_pc) else fail_value("fetch address", exp_pc, imem_addr);
            end
            if (retire_valid) check_retire();
        end
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
        imem_req |-> !outstanding)
        else fail_plain("imem_req raised while a fetch was still outstanding");

    a_retire_after_valid: assert property (@(posedge clk) disable iff (reset)
        imem_valid |=> retire_valid)
        else fail_plain("no retire on the cycle after imem_valid");

    a_retire_needs_valid: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> $past(imem_valid))
        else fail_plain("retire without imem_valid on the previous cycle");

    a_req_after_retire: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> imem_req)
        else fail_plain("no fetch request on the cycle after retire");

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired with %0d instructions retired", retire_count);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: vlog.f
common/rv_isa_pkg.sv
common/core_cfg_pkg.sv
fetch/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/core_top.sv
tb/core_tb.sv
